// File: common/binconv_macros.svh
////////////////////////////////////////////////////////////
// geometry and widths of the 2x2 tile binary-conv array
// the row mapping in the dispatcher assumes exactly this
// geometry, so change these values only together with it
////////////////////////////////////////////////////////////

`ifndef BINCONV_MACROS_SVH
`define BINCONV_MACROS_SVH

// processing columns, one per output pixel of the tile
`define NR_PE 4
// tile is PE_W x PE_W pixels
`define PE_W 2
// rows per column, one per 3x3 tap or per 1x1 channel
`define COLUMN_SIZE 9

// activation buffer, INBUF_W x INBUF_W pixels of NR_CH channels
`define INBUF_W 4
`define NR_CH 9
`define NR_ACT (`INBUF_W * `INBUF_W * `NR_CH)
`define ACT_W 8

// weight precision and bit plane index
`define QW_MAX 8
`define BIT_IDX_W $clog2(`QW_MAX)

// nine times 255 needs 12 bits, partial result is signed
`define COL_SUM_W 12
`define PRES_W 22

`endif

// File: common/binconv_pkg.sv
////////////////////////////////////////////////////////////
// types shared by all blocks of the binary-conv array
// widths come from the macro header
////////////////////////////////////////////////////////////

`default_nettype none

`include "binconv_macros.svh"

package binconv_pkg;

  // how the activation buffer is mapped onto the column rows
  typedef enum logic [0:0] {
    FILTER_1X1 = 1'b0,
    FILTER_3X3 = 1'b1
  } filter_mode_e;

  // one unsigned activation
  typedef logic [`ACT_W-1:0] act_t;

  // weight bit plane index, 0 is the lsb plane
  typedef logic [`BIT_IDX_W-1:0] bit_idx_t;

  // binary dot product of one column, unsigned
  typedef logic [`COL_SUM_W-1:0] col_sum_t;

  // accumulated partial result per column
  typedef logic signed [`PRES_W-1:0] pres_t;

endpackage

`default_nettype wire

// File: compile.f
+incdir+common
common/binconv_pkg.sv
design/binconv_dispatch.sv
design/binconv_column.sv
design/binconv_accumulator.sv
design/binconv_array.sv
tests/tb_binconv_array.sv

// File: design/binconv_accumulator.sv
////////////////////////////////////////////////////////////
// shift and add of the bit plane sums, two's complement
// the last plane is the sign plane and is subtracted
// flags of column 0 stand for all columns
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "binconv_macros.svh"

module binconv_accumulator import binconv_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   sum_valid_i,
  input  bit_idx_t               sum_bit_idx_i,
  input  logic                   sum_last_i,
  input  col_sum_t [`NR_PE-1:0]  col_sum_i,
  output pres_t [`NR_PE-1:0]     pres_o,
  output logic                   pres_valid_o
);

  // running value per column
  pres_t [`NR_PE-1:0] acc_q;
  pres_t [`NR_PE-1:0] acc_d;

  always_comb begin : acc_comb
    pres_t base;
    pres_t term;
    acc_d = acc_q;
    for (int p = 0; p < `NR_PE; p++) begin
      // plane 0 opens a new group
      base = (sum_bit_idx_i == '0) ? '0 : acc_q[p];
      // weight of this plane is 2^bit_idx
      term = pres_t'(col_sum_i[p]) << sum_bit_idx_i;
      if (sum_valid_i) begin
        acc_d[p] = sum_last_i ? base - term : base + term;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q        <= '0;
      pres_o       <= '0;
      pres_valid_o <= 1'b0;
    end else begin
      acc_q        <= acc_d;
      // single cycle pulse after the sign plane
      pres_valid_o <= sum_valid_i & sum_last_i;
      if (sum_valid_i && sum_last_i) begin
        // results hold until the next group completes
        pres_o <= acc_d;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/binconv_array.sv
////////////////////////////////////////////////////////////
// 2x2 tile binary-conv array, no back-pressure
// pres_valid_o follows the last beat by three registers
// keep clear_i high 3 cycles so beats in flight drain
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "binconv_macros.svh"

module binconv_array import binconv_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       valid_i,
  input  filter_mode_e               mode_i,
  input  logic [`BIT_IDX_W:0]        qw_i,
  input  act_t [`NR_ACT-1:0]         act_i,
  input  logic [`COLUMN_SIZE-1:0]    weight_i,
  output pres_t [`NR_PE-1:0]         pres_o,
  output logic                       pres_valid_o
);

  // dispatcher to columns
  logic                                beat_valid;
  bit_idx_t                            bit_idx;
  logic                                last;
  act_t [`NR_PE-1:0][`COLUMN_SIZE-1:0] row_act;
  logic [`COLUMN_SIZE-1:0]             weight;

  // columns to accumulator, flags from column 0 only
  logic                                sum_valid;
  bit_idx_t                            sum_bit_idx;
  logic                                sum_last;
  col_sum_t [`NR_PE-1:0]               col_sum;

  binconv_dispatch i_dispatch (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .valid_i      ( valid_i    ),
    .mode_i       ( mode_i     ),
    .qw_i         ( qw_i       ),
    .act_i        ( act_i      ),
    .weight_i     ( weight_i   ),
    .beat_valid_o ( beat_valid ),
    .bit_idx_o    ( bit_idx    ),
    .last_o       ( last       ),
    .row_act_o    ( row_act    ),
    .weight_o     ( weight     )
  );

  for (genvar p = 0; p < `NR_PE; p++) begin : gen_column
    if (p == 0) begin : gen_lead
      // column 0 also carries the valid and flags for the array
      binconv_column i_column (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .beat_valid_i  ( beat_valid  ),
        .bit_idx_i     ( bit_idx     ),
        .last_i        ( last        ),
        .row_act_i     ( row_act[p]  ),
        .weight_i      ( weight      ),
        .sum_valid_o   ( sum_valid   ),
        .sum_bit_idx_o ( sum_bit_idx ),
        .sum_last_o    ( sum_last    ),
        .col_sum_o     ( col_sum[p]  )
      );
    end else begin : gen_follow
      binconv_column i_column (
        .clk_i         ( clk_i      ),
        .rst_ni        ( rst_ni     ),
        .beat_valid_i  ( beat_valid ),
        .bit_idx_i     ( bit_idx    ),
        .last_i        ( last       ),
        .row_act_i     ( row_act[p] ),
        .weight_i      ( weight     ),
        .sum_valid_o   (            ),
        .sum_bit_idx_o (            ),
        .sum_last_o    (            ),
        .col_sum_o     ( col_sum[p] )
      );
    end
  end

  binconv_accumulator i_accumulator (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .sum_valid_i   ( sum_valid    ),
    .sum_bit_idx_i ( sum_bit_idx  ),
    .sum_last_i    ( sum_last     ),
    .col_sum_i     ( col_sum      ),
    .pres_o        ( pres_o       ),
    .pres_valid_o  ( pres_valid_o )
  );

endmodule

`default_nettype wire

// File: design/binconv_column.sv
////////////////////////////////////////////////////////////
// one column of nine rows, one bit plane per beat
// result is registered, flags are delayed alongside it
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "binconv_macros.svh"

module binconv_column import binconv_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       beat_valid_i,
  input  bit_idx_t                   bit_idx_i,
  input  logic                       last_i,
  input  act_t [`COLUMN_SIZE-1:0]    row_act_i,
  input  logic [`COLUMN_SIZE-1:0]    weight_i,
  output logic                       sum_valid_o,
  output bit_idx_t                   sum_bit_idx_o,
  output logic                       sum_last_o,
  output col_sum_t                   col_sum_o
);

  col_sum_t sum_d;

  // binary dot product, a set weight bit passes its activation
  always_comb begin
    sum_d = '0;
    for (int r = 0; r < `COLUMN_SIZE; r++) begin
      if (weight_i[r]) begin
        sum_d = sum_d + col_sum_t'(row_act_i[r]);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_valid_o   <= 1'b0;
      sum_bit_idx_o <= '0;
      sum_last_o    <= 1'b0;
    end else begin
      sum_valid_o <= beat_valid_i;
      if (beat_valid_i) begin
        sum_bit_idx_o <= bit_idx_i;
        sum_last_o    <= last_i;
      end
    end
  end

  // sum only moves on a beat
  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      col_sum_o <= sum_d;
    end
  end

endmodule

`default_nettype wire

// File: design/binconv_dispatch.sv
////////////////////////////////////////////////////////////
// mode_i and qw_i must stay stable over a whole group
// qw_i of 0 is not supported, 1 to 8 only
// clear_i drops the beat of its cycle and restarts at plane 0
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "binconv_macros.svh"

module binconv_dispatch import binconv_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clear_i,
  input  logic                                valid_i,
  input  filter_mode_e                        mode_i,
  input  logic [`BIT_IDX_W:0]                 qw_i,
  input  act_t [`NR_ACT-1:0]                  act_i,
  input  logic [`COLUMN_SIZE-1:0]             weight_i,
  output logic                                beat_valid_o,
  output bit_idx_t                            bit_idx_o,
  output logic                                last_o,
  output act_t [`NR_PE-1:0][`COLUMN_SIZE-1:0] row_act_o,
  output logic [`COLUMN_SIZE-1:0]             weight_o
);

  // mapped activations before the beat register
  act_t [`NR_PE-1:0][`COLUMN_SIZE-1:0] row_act_d;

  // shared block counter, same plane for every column
  bit_idx_t cnt_q;
  logic     cnt_last;

  ////////////////////////////////////////////////////////////
  // activation mapping
  ////////////////////////////////////////////////////////////

  for (genvar p = 0; p < `NR_PE; p++) begin : gen_pe
    // pixel of this column inside the buffer
    localparam int unsigned pix_row = p / `PE_W;
    localparam int unsigned pix_col = p % `PE_W;

    for (genvar r = 0; r < `COLUMN_SIZE; r++) begin : gen_row
      // 1x1: channel r of the own pixel
      localparam int unsigned idx_1x1 =
        (pix_row * `INBUF_W + pix_col) * `NR_CH + r;
      // 3x3: channel 0 of the pixel at tap offset (r/3, r%3)
      localparam int unsigned idx_3x3 =
        ((pix_row + r / 3) * `INBUF_W + pix_col + r % 3) * `NR_CH;

      assign row_act_d[p][r] = (mode_i == FILTER_1X1) ? act_i[idx_1x1] : act_i[idx_3x3];
    end
  end

  ////////////////////////////////////////////////////////////
  // block counter and beat control
  ////////////////////////////////////////////////////////////

  // sign plane reached, counter wraps on this beat
  assign cnt_last = ({1'b0, cnt_q} == qw_i - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q        <= '0;
      beat_valid_o <= 1'b0;
      bit_idx_o    <= '0;
      last_o       <= 1'b0;
    end else if (clear_i) begin
      // abort, any beat of this cycle is lost
      cnt_q        <= '0;
      beat_valid_o <= 1'b0;
    end else begin
      beat_valid_o <= valid_i;
      if (valid_i) begin
        cnt_q     <= cnt_last ? '0 : cnt_q + 1'b1;
        // index and last flag travel with the beat
        bit_idx_o <= cnt_q;
        last_o    <= cnt_last;
      end
    end
  end

  // beat payload, only loaded when a plane arrives
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      row_act_o <= row_act_d;
      // the plane is broadcast, every column sees the same bits
      weight_o  <= weight_i;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the binconv array testbench with verilator and runs it
# the verdict comes from the simulation log

set -u
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing -j 0 \
  -f compile.f \
  --top-module tb_binconv_array \
  -o sim_tb_binconv_array \
  && ./obj_dir/sim_tb_binconv_array > "$log" 2>&1 \
  || echo "build or simulation error" >> "$log"

cat "$log"

grep -q "sim failed" "$log" && { echo "RESULT: FAIL"; exit 1; }
grep -q "sim passed" "$log" || { echo "RESULT: FAIL, no verdict in log"; exit 1; }
echo "RESULT: PASS"
exit 0

// File: tests/tb_binconv_array.sv
////////////////////////////////////////////////////////////
// testbench for the 2x2 tile binary-conv array
// activations are held over a group and weights change per beat
// the result pulse is due three clock edges after the drive
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "binconv_macros.svh"

module tb_binconv_array import binconv_pkg::*; ();

  typedef pres_t [`NR_PE-1:0]            tile_t;
  typedef logic [`COLUMN_SIZE-1:0]       plane_t;
  typedef plane_t [`QW_MAX-1:0]          planes_t;
  typedef act_t [`NR_ACT-1:0]            acts_t;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 clear_i;
  logic                 valid_i;
  filter_mode_e         mode_i;
  logic [`BIT_IDX_W:0]  qw_i;
  acts_t                act_i;
  plane_t               weight_i;
  tile_t                pres_o;
  logic                 pres_valid_o;

  logic [31:0] lfsr_q = 32'heb12;
  int          cycle_cnt = 0;
  int          value_errs = 0;
  int          pulse_errs = 0;
  int          lat_errs = 0;

  // expected tiles and the cycle of their pulse
  tile_t exp_q[$];
  int    exp_cyc_q[$];

  binconv_array i_dut (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .valid_i      ( valid_i      ),
    .mode_i       ( mode_i       ),
    .qw_i         ( qw_i         ),
    .act_i        ( act_i        ),
    .weight_i     ( weight_i     ),
    .pres_o       ( pres_o       ),
    .pres_valid_o ( pres_valid_o )
  );

  // 20 ns period
  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // dot product of column p with two's complement row weights
  function automatic int ref_column(input acts_t acts, input filter_mode_e mode,
                                    input int qw, input planes_t planes, input int p);
    int pr;
    int pc;
    int idx;
    int w;
    int acc;
    pr  = p / `PE_W;
    pc  = p % `PE_W;
    acc = 0;
    for (int r = 0; r < `COLUMN_SIZE; r++) begin
      if (mode == FILTER_3X3) begin
        idx = ((pr + r / 3) * `INBUF_W + pc + r % 3) * `NR_CH;
      end else begin
        idx = (pr * `INBUF_W + pc) * `NR_CH + r;
      end
      w = 0;
      for (int b = 0; b < qw; b++) begin
        if (planes[b][r]) begin
          // top plane counts negative
          if (b == qw - 1) begin
            w = w - (1 << b);
          end else begin
            w = w + (1 << b);
          end
        end
      end
      acc = acc + int'(acts[idx]) * w;
    end
    return acc;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus tasks entered and left on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic run_group(input filter_mode_e mode, input int qw, input bit with_gaps);
    acts_t   acts;
    planes_t planes;
    tile_t   exp_tile;
    int      gap;
    planes = '0;
    for (int i = 0; i < `NR_ACT; i++) begin
      acts[i] = act_t'(rand_bits(`ACT_W));
    end
    for (int b = 0; b < qw; b++) begin
      planes[b] = plane_t'(rand_bits(`COLUMN_SIZE));
    end
    for (int p = 0; p < `NR_PE; p++) begin
      exp_tile[p] = pres_t'(ref_column(acts, mode, qw, planes, p));
    end
    mode_i = mode;
    qw_i   = 4'(qw);
    for (int b = 0; b < qw; b++) begin
      gap = with_gaps ? int'(rand_bits(2)) : 0;
      // idle cycles carry junk that must be ignored
      repeat (gap) begin
        valid_i  = 1'b0;
        weight_i = plane_t'(rand_bits(`COLUMN_SIZE));
        act_i    = ~acts;
        @(negedge clk_i);
      end
      valid_i  = 1'b1;
      weight_i = planes[b];
      act_i    = acts;
      if (b == qw - 1) begin
        exp_q.push_back(exp_tile);
        exp_cyc_q.push_back(cycle_cnt + 3);
      end
      @(negedge clk_i);
    end
    valid_i = 1'b0;
  endtask

  // four planes of a qw 5 group and the sign plane under clear
  task automatic abort_group();
    acts_t acts;
    for (int i = 0; i < `NR_ACT; i++) begin
      acts[i] = act_t'(rand_bits(`ACT_W));
    end
    mode_i = FILTER_3X3;
    qw_i   = 4'd5;
    for (int b = 0; b < 4; b++) begin
      valid_i  = 1'b1;
      weight_i = plane_t'(rand_bits(`COLUMN_SIZE));
      act_i    = acts;
      @(negedge clk_i);
    end
    // the sign plane meets the clear and must not finish the group
    weight_i = plane_t'(rand_bits(`COLUMN_SIZE));
    clear_i  = 1'b1;
    @(negedge clk_i);
    valid_i = 1'b0;
    repeat (2) @(negedge clk_i);
    clear_i = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 100) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      pulse_errs++;
      $display("results still pending after 100 cycles of waiting");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // comparison process sampling on the falling edge
  ////////////////////////////////////////////////////////////

  initial begin : compare
    tile_t exp_tile;
    int    exp_cyc;
    int    wait_cnt;
    wait_cnt = 0;
    forever begin
      @(negedge clk_i);
      if (pres_valid_o) begin
        wait_cnt = 0;
        if (exp_q.size() == 0) begin
          pulse_errs++;
          $display("unexpected result pulse at %0t", $time);
        end else begin
          exp_tile = exp_q.pop_front();
          exp_cyc  = exp_cyc_q.pop_front();
          if (cycle_cnt != exp_cyc) begin
            lat_errs++;
            $display("result pulse at cycle %0d, expected at cycle %0d", cycle_cnt, exp_cyc);
          end
          for (int p = 0; p < `NR_PE; p++) begin
            if (pres_o[p] != exp_tile[p]) begin
              value_errs++;
              $display("Fail %0t: column %0d result %0d, expected %0d",
                       $time, p, pres_o[p], exp_tile[p]);
            end
          end
        end
      end else if (exp_q.size() != 0) begin
        wait_cnt++;
        if (wait_cnt > 40) begin
          pulse_errs++;
          $display("no result pulse within 40 cycles of the last beat");
          void'(exp_q.pop_front());
          void'(exp_cyc_q.pop_front());
          wait_cnt = 0;
        end
      end
    end
  end

  // hard limit on the run
  initial begin : watchdog
    repeat (20000) @(posedge clk_i);
    $display("simulation did not finish within 20000 cycles");
    $display("sim failed");
    $finish;
  end

  initial begin : stimulus
    int qw;
    rst_ni   = 1'b0;
    clear_i  = 1'b0;
    valid_i  = 1'b0;
    mode_i   = FILTER_3X3;
    qw_i     = 4'd8;
    act_i    = '0;
    weight_i = '0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    // idle before the first beat
    repeat (10) @(negedge clk_i);
    if (pres_o != '0) begin
      value_errs++;
      $display("Fail %0t: results not zero after reset", $time);
    end
    // 3x3 full precision with back to back beats
    run_group(FILTER_3X3, 8, 1'b0);
    run_group(FILTER_3X3, 8, 1'b0);
    wait_drain();
    // 1x1 with random precision
    repeat (4) begin
      qw = 1 + int'(rand_bits(3));
      run_group(FILTER_1X1, qw, 1'b0);
    end
    wait_drain();
    // qw 1, 3 and 5 in both modes
    for (int k = 1; k <= 5; k += 2) begin
      run_group(FILTER_3X3, k, 1'b0);
      run_group(FILTER_1X1, k, 1'b0);
    end
    wait_drain();
    // idle gaps between beats
    run_group(FILTER_3X3, 4, 1'b1);
    run_group(FILTER_1X1, 6, 1'b1);
    run_group(FILTER_3X3, 8, 1'b1);
    wait_drain();
    // aborted group then a full one
    abort_group();
    run_group(FILTER_3X3, 8, 1'b0);
    wait_drain();
    repeat (10) @(negedge clk_i);
    $display("errors: value %0d, pulse %0d, latency %0d", value_errs, pulse_errs, lat_errs);
    if (value_errs + pulse_errs + lat_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
